// File: verilog/fetch_settings.svh
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// Data and address width
`define XLEN        32

// First fetch address out of reset
`define RESET_PC    32'h8000_0000

`define BTB_ENTRIES 16   // Index from PC bits 5:2
`define IMEM_WORDS  256  // Index from PC bits 9:2

`endif

// File: verilog/fetch_pkg.sv
`include "fetch_settings.svh"

package fetch_pkg;

    // Fetch address
    typedef logic [`XLEN-1:0] pc_t;

    // Raw RV32 instruction word
    typedef logic [31:0] instr_t;

    // Outcome of a resolved branch, carried with a squash
    typedef enum logic {
        RD_NOT_TAKEN = 1'b0,
        RD_TAKEN     = 1'b1
    } redirect_t;

endpackage

// File: verilog/bpred.sv
`timescale 1ns/1ps
`include "fetch_settings.svh"

module bpred
    import fetch_pkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    // Lookup for the current fetch PC
    input  pc_t       pc,
    output logic      pred_hit,
    output pc_t       pred_next,
    // Training from the resolved branch
    input  logic      squash_valid,
    input  redirect_t squash_kind,
    input  pc_t       squash_pc,
    input  pc_t       squash_target
);

    localparam int IDX_W = $clog2(`BTB_ENTRIES);
    localparam int TAG_W = `XLEN - IDX_W - 2;

    logic [`BTB_ENTRIES-1:0] valid_q;
    logic [TAG_W-1:0]        tag_q    [`BTB_ENTRIES];
    pc_t                     target_q [`BTB_ENTRIES];

    logic [IDX_W-1:0] rd_idx;
    logic [TAG_W-1:0] rd_tag;
    logic [IDX_W-1:0] wr_idx;
    logic [TAG_W-1:0] wr_tag;
    logic             wr_match;

    // Word aligned PC, so bits 1:0 are skipped
    assign rd_idx = pc[IDX_W+1:2];
    assign rd_tag = pc[`XLEN-1:IDX_W+2];
    assign wr_idx = squash_pc[IDX_W+1:2];
    assign wr_tag = squash_pc[`XLEN-1:IDX_W+2];

    // Combinational lookup
    assign pred_hit  = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
    assign pred_next = pred_hit ? target_q[rd_idx] : pc + pc_t'(4);

    // Entry currently holding the squashed branch
    assign wr_match = valid_q[wr_idx] && (tag_q[wr_idx] == wr_tag);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q <= '0;
        end else if (squash_valid) begin
            if (squash_kind == RD_TAKEN) begin
                valid_q[wr_idx] <= 1'b1;      // Allocate or overwrite
            end else if (wr_match) begin
                valid_q[wr_idx] <= 1'b0;      // Branch fell through, forget it
            end
        end
    end

    // Tag and target only change together with a taken squash
    always_ff @(posedge clk) begin
        if (squash_valid && squash_kind == RD_TAKEN) begin
            tag_q[wr_idx]    <= wr_tag;
            target_q[wr_idx] <= squash_target;
        end
    end

endmodule

// File: verilog/imem.sv
`timescale 1ns/1ps
`include "fetch_settings.svh"

module imem
    import fetch_pkg::*;
(
    input  logic   clk,
    input  logic   rstn,
    // Request side
    input  logic   addr_valid,
    input  pc_t    addr,
    output logic   addr_ready,
    // Response side
    output logic   data_valid,
    output instr_t data,
    input  logic   data_ready,
    input  logic   flush,       // Drops the response register
    // Preload port, used while reset is held
    input  logic   load_en,
    input  pc_t    load_addr,
    input  instr_t load_data
);

    localparam int AW = $clog2(`IMEM_WORDS);

    instr_t mem [`IMEM_WORDS];
    logic   accept;

    // New request only when the response register is free or being drained
    assign addr_ready = !data_valid || data_ready;
    assign accept     = addr_valid && addr_ready;

    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr[AW+1:2]] <= load_data;
        end
    end

    // Synchronous read, held until the next accepted request
    always_ff @(posedge clk) begin
        if (accept) begin
            data <= mem[addr[AW+1:2]];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            data_valid <= 1'b0;
        end else if (flush) begin
            data_valid <= 1'b0;
        end else if (accept) begin
            data_valid <= 1'b1;
        end else if (data_ready) begin
            data_valid <= 1'b0;               // Taken with no follow-up request
        end
    end

endmodule

// File: verilog/fetch.sv
`timescale 1ns/1ps
`include "fetch_settings.svh"

module fetch
    import fetch_pkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    // Redirect from a later stage
    input  logic      squash_valid,
    input  redirect_t squash_kind,
    input  pc_t       squash_pc,
    input  pc_t       squash_target,
    // Predictor
    output pc_t       pc,
    input  logic      pred_hit,
    input  pc_t       pred_next,
    // Instruction memory
    output logic      addr_valid,
    output pc_t       addr,
    input  logic      addr_ready,
    input  logic      data_valid,
    input  instr_t    data,
    output logic      data_ready,
    // Decode
    output logic      fetch_valid,
    output pc_t       fetch_pc,
    output instr_t    fetch_instr,
    output logic      fetch_pred_hit,
    output pc_t       fetch_pred_next,
    input  logic      fetch_ready
);

    pc_t  pc_q;
    pc_t  redirect_pc;
    logic issue;

    // Record of the request whose response is in flight or held
    pc_t  req_pc_q;
    logic req_hit_q;
    pc_t  req_next_q;
    logic req_killed_q;

    // Decode stall blocks issue so the held response never gets overwritten
    assign issue = addr_ready && fetch_ready && !squash_valid;

    assign redirect_pc = (squash_kind == RD_TAKEN) ? squash_target
                                                   : squash_pc + pc_t'(4);

    assign pc         = pc_q;
    assign addr       = pc_q;
    assign addr_valid = issue;
    assign data_ready = fetch_ready;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            pc_q <= `RESET_PC;
        end else if (squash_valid) begin
            pc_q <= redirect_pc;
        end else if (issue) begin
            pc_q <= pred_next;             // Sequential or predicted target
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            req_pc_q   <= pc_q;
            req_hit_q  <= pred_hit;
            req_next_q <= pred_next;
        end
    end

    // Nothing valid outstanding out of reset or after a squash
    always_ff @(posedge clk) begin
        if (!rstn) begin
            req_killed_q <= 1'b1;
        end else if (squash_valid) begin
            req_killed_q <= 1'b1;
        end else if (issue) begin
            req_killed_q <= 1'b0;
        end
    end

    // The squash cycle itself never delivers a word
    assign fetch_valid     = data_valid && !req_killed_q && !squash_valid;
    assign fetch_pc        = req_pc_q;
    assign fetch_instr     = data;
    assign fetch_pred_hit  = req_hit_q;
    assign fetch_pred_next = req_next_q;

endmodule

// File: verilog/fetch_top.sv
`timescale 1ns/1ps

module fetch_top
    import fetch_pkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    // Decode interface
    output logic      fetch_valid,
    output pc_t       fetch_pc,
    output instr_t    fetch_instr,
    output logic      fetch_pred_hit,
    output pc_t       fetch_pred_next,
    input  logic      fetch_ready,
    // Squash from execute
    input  logic      squash_valid,
    input  redirect_t squash_kind,
    input  pc_t       squash_pc,
    input  pc_t       squash_target,
    // Memory preload
    input  logic      load_en,
    input  pc_t       load_addr,
    input  instr_t    load_data
);

    pc_t    cur_pc;
    logic   pred_hit;
    pc_t    pred_next;
    logic   addr_valid;
    pc_t    addr;
    logic   addr_ready;
    logic   data_valid;
    instr_t data;
    logic   data_ready;

    fetch fetch_i (
        .clk            (clk),
        .rstn           (rstn),
        .squash_valid   (squash_valid),
        .squash_kind    (squash_kind),
        .squash_pc      (squash_pc),
        .squash_target  (squash_target),
        .pc             (cur_pc),
        .pred_hit       (pred_hit),
        .pred_next      (pred_next),
        .addr_valid     (addr_valid),
        .addr           (addr),
        .addr_ready     (addr_ready),
        .data_valid     (data_valid),
        .data           (data),
        .data_ready     (data_ready),
        .fetch_valid    (fetch_valid),
        .fetch_pc       (fetch_pc),
        .fetch_instr    (fetch_instr),
        .fetch_pred_hit (fetch_pred_hit),
        .fetch_pred_next(fetch_pred_next),
        .fetch_ready    (fetch_ready)
    );

    bpred bpred_i (
        .clk          (clk),
        .rstn         (rstn),
        .pc           (cur_pc),
        .pred_hit     (pred_hit),
        .pred_next    (pred_next),
        .squash_valid (squash_valid),
        .squash_kind  (squash_kind),
        .squash_pc    (squash_pc),
        .squash_target(squash_target)
    );

    imem imem_i (
        .clk       (clk),
        .rstn      (rstn),
        .addr_valid(addr_valid),
        .addr      (addr),
        .addr_ready(addr_ready),
        .data_valid(data_valid),
        .data      (data),
        .data_ready(data_ready),
        .flush     (squash_valid),   // Squash drops any response
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data)
    );

endmodule

// File: tests/fetch_chk.sv
`timescale 1ns/1ps

module fetch_chk
    import fetch_pkg::*;
(
    input logic   clk,
    input logic   rstn,
    input logic   squash_valid,
    input logic   addr_valid,
    input logic   fetch_valid,
    input logic   fetch_ready,
    input pc_t    fetch_pc,
    input instr_t fetch_instr,
    input logic   fetch_pred_hit,
    input pc_t    fetch_pred_next
);

    int issue_errs = 0;
    int valid_errs = 0;
    int hold_errs  = 0;

    // Every issued request comes back as a word one cycle later
    issue_then_valid: assert property (@(posedge clk) disable iff (!rstn)
        addr_valid |=> fetch_valid || squash_valid)
        else begin
            $error("Issued request did not return a word on the next cycle");
            issue_errs++;
        end

    no_valid_after_squash: assert property (@(posedge clk) disable iff (!rstn)
        squash_valid |=> !fetch_valid)   // Word in flight or held is dropped
        else begin
            $error("fetch_valid high in the cycle after a squash");
            valid_errs++;
        end

    // Stalled word stays put unless a squash drops it
    hold_while_stalled: assert property (@(posedge clk) disable iff (!rstn)
        fetch_valid && !fetch_ready |=> squash_valid ||
            (fetch_valid && $stable(fetch_pc) && $stable(fetch_instr)
             && $stable(fetch_pred_hit) && $stable(fetch_pred_next)))
        else begin
            $error("Decode outputs changed while stalled");
            hold_errs++;
        end

endmodule

bind fetch fetch_chk chk_i (
    .clk            (clk),
    .rstn           (rstn),
    .squash_valid   (squash_valid),
    .addr_valid     (addr_valid),
    .fetch_valid    (fetch_valid),
    .fetch_ready    (fetch_ready),
    .fetch_pc       (fetch_pc),
    .fetch_instr    (fetch_instr),
    .fetch_pred_hit (fetch_pred_hit),
    .fetch_pred_next(fetch_pred_next)
);

// File: tests/fetch_monitor.sv
`timescale 1ns/1ps
`include "fetch_settings.svh"

module fetch_monitor
    import fetch_pkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    input  logic      fetch_valid,
    input  pc_t       fetch_pc,
    input  instr_t    fetch_instr,
    input  logic      fetch_pred_hit,
    input  pc_t       fetch_pred_next,
    input  logic      fetch_ready,
    input  logic      squash_valid,
    input  redirect_t squash_kind,
    input  pc_t       squash_pc,
    input  pc_t       squash_target,
    input  logic      load_en,
    input  pc_t       load_addr,
    input  instr_t    load_data,
    input  int        test_id,
    input  logic      test_done,
    input  logic      all_done,
    output int        err_count
);

    localparam int IDX_W = $clog2(`BTB_ENTRIES);
    localparam int MEM_W = $clog2(`IMEM_WORDS);

    instr_t                  mem_ref    [`IMEM_WORDS];
    logic [`BTB_ENTRIES-1:0] btb_valid;
    pc_t                     btb_pc     [`BTB_ENTRIES];  // Whole branch PC as tag
    pc_t                     btb_target [`BTB_ENTRIES];
    pc_t                     exp_pc;
    int                      test_xfers;
    int                      test_errs;
    int                      total_xfers;

    // Expected next PC and hit for a fetch at pc
    function automatic pc_t predict(input pc_t pc, output logic hit);
        logic [IDX_W-1:0] idx;
        idx = pc[IDX_W+1:2];
        hit = btb_valid[idx] && (btb_pc[idx] == pc);
        return hit ? btb_target[idx] : pc + 32'd4;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
            test_errs++;
            err_count++;
        end
    endtask

    always @(posedge clk) begin
        logic             hit;
        pc_t              nxt;
        logic [IDX_W-1:0] idx;
        if (load_en) mem_ref[load_addr[MEM_W+1:2]] = load_data;
        if (!rstn) begin
            exp_pc      = `RESET_PC;
            btb_valid   = '0;
            err_count   = 0;
            test_xfers  = 0;
            test_errs   = 0;
            total_xfers = 0;
        end else if (squash_valid) begin
            idx = squash_pc[IDX_W+1:2];
            if (squash_kind == RD_TAKEN) begin
                btb_valid[idx]  = 1'b1;
                btb_pc[idx]     = squash_pc;
                btb_target[idx] = squash_target;
                exp_pc          = squash_target;
            end else begin
                if (btb_valid[idx] && btb_pc[idx] == squash_pc) btb_valid[idx] = 1'b0;
                exp_pc = squash_pc + 32'd4;
            end
        end else if (fetch_valid && fetch_ready) begin
            nxt = predict(exp_pc, hit);
            check_value("fetch_pc", fetch_pc, exp_pc);
            check_value("fetch_instr", fetch_instr, mem_ref[exp_pc[MEM_W+1:2]]);
            check_value("fetch_pred_hit", 32'(fetch_pred_hit), 32'(hit));
            check_value("fetch_pred_next", fetch_pred_next, nxt);
            exp_pc = nxt;
            test_xfers++;
            total_xfers++;
        end
        if (test_done) begin
            $display("Test %0d finished: %0d transfers, %0d errors",
                     test_id, test_xfers, test_errs);
            test_xfers = 0;
            test_errs  = 0;
        end
        if (all_done)
            $display("Totals: %0d tests, %0d transfers, %0d errors",
                     test_id, total_xfers, err_count);
    end

endmodule

// File: tests/fetch_tb.sv
`timescale 1ns/1ps
`include "fetch_settings.svh"

module fetch_tb
    import fetch_pkg::*;
();

    localparam int  XFER_SUM    = 20 + 40 + 12 + 30 + 10 + 12;
    localparam int  CYCLE_LIMIT = XFER_SUM * 4 + 200;
    localparam pc_t BASE        = `RESET_PC;

    logic      clk;
    logic      rstn;
    logic      fetch_valid;
    pc_t       fetch_pc;
    instr_t    fetch_instr;
    logic      fetch_pred_hit;
    pc_t       fetch_pred_next;
    logic      fetch_ready;
    logic      squash_valid;
    redirect_t squash_kind;
    pc_t       squash_pc;
    pc_t       squash_target;
    logic      load_en;
    pc_t       load_addr;
    instr_t    load_data;

    int          test_id;
    logic        test_done;
    logic        all_done;
    int          mon_errs;
    int          xfer_total = 0;
    int          run_cycles = 0;
    logic [15:0] lfsr_q     = 16'd20870;

    fetch_top dut_i (.*);

    fetch_monitor mon_i (.*, .err_count(mon_errs));

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Fibonacci LFSR, taps 16 14 13 11
    function automatic logic lfsr_bit();
        logic fb;
        fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
        lfsr_q = {lfsr_q[14:0], fb};
        return fb;
    endfunction

    function automatic instr_t lfsr_word();
        instr_t w;
        w = '0;
        for (int b = 0; b < 32; b++) w = {w[30:0], lfsr_bit()};
        return w;
    endfunction

    always @(posedge clk) begin
        if (rstn && fetch_valid && fetch_ready) xfer_total <= xfer_total + 1;
    end

    always @(posedge clk) begin
        if (rstn) begin
            run_cycles <= run_cycles + 1;
            if (run_cycles >= CYCLE_LIMIT) begin
                $display("Timeout: tests did not finish within %0d cycles", CYCLE_LIMIT);
                $display("Verification failed");
                $finish;
            end
        end
    end

    task automatic load_memory();
        for (int i = 0; i < `IMEM_WORDS; i++) begin
            @(posedge clk);
            load_en   <= 1'b1;
            load_addr <= BASE + pc_t'(i * 4);
            load_data <= lfsr_word();
        end
        @(posedge clk);
        load_en <= 1'b0;
    endtask

    task automatic wait_xfers(input int n);
        int target;
        target = xfer_total + n;
        while (xfer_total < target) @(posedge clk);
    endtask

    // Decode ready toggles randomly each cycle
    task automatic random_ready_xfers(input int n);
        int target;
        target = xfer_total + n;
        while (xfer_total < target) begin
            @(posedge clk);
            fetch_ready <= lfsr_bit();
        end
        fetch_ready <= 1'b1;
    endtask

    task automatic send_squash(input redirect_t kind, input pc_t spc, input pc_t tgt);
        @(posedge clk);
        squash_valid  <= 1'b1;
        squash_kind   <= kind;
        squash_pc     <= spc;
        squash_target <= tgt;
        @(posedge clk);
        squash_valid <= 1'b0;
    endtask

    task automatic end_test(input int id);
        @(posedge clk);
        test_id   <= id;
        test_done <= 1'b1;
        @(posedge clk);
        test_done <= 1'b0;
    endtask

    initial begin
        int chk_errs;
        rstn          = 1'b0;
        fetch_ready   = 1'b1;
        squash_valid  = 1'b0;
        squash_kind   = RD_NOT_TAKEN;
        squash_pc     = '0;
        squash_target = '0;
        load_en       = 1'b0;
        load_addr     = '0;
        load_data     = '0;
        test_id       = 0;
        test_done     = 1'b0;
        all_done      = 1'b0;

        load_memory();                       // Preload runs under reset
        repeat (4) @(posedge clk);
        rstn <= 1'b1;

        wait_xfers(20);                      // Sequential stream from reset
        end_test(1);
        random_ready_xfers(40);
        end_test(2);
        send_squash(RD_NOT_TAKEN, BASE + 32'h200, '0);
        wait_xfers(12);
        end_test(3);
        send_squash(RD_TAKEN, BASE + 32'h80, BASE + 32'h20);   // Loop 0x20 to 0x80
        wait_xfers(30);
        end_test(4);

        // Stall until a word is held, then squash it away
        @(posedge clk);
        fetch_ready <= 1'b0;
        do @(posedge clk); while (!fetch_valid);
        repeat (2) @(posedge clk);
        send_squash(RD_NOT_TAKEN, BASE + 32'h100, '0);
        fetch_ready <= 1'b1;
        wait_xfers(10);
        end_test(5);

        send_squash(RD_NOT_TAKEN, BASE + 32'h80, '0);   // Clears the trained entry
        send_squash(RD_NOT_TAKEN, BASE + 32'h6c, '0);   // Rewind to 0x70
        wait_xfers(12);
        end_test(6);

        @(posedge clk);
        all_done <= 1'b1;
        @(posedge clk);
        all_done <= 1'b0;
        @(posedge clk);
        chk_errs = dut_i.fetch_i.chk_i.issue_errs + dut_i.fetch_i.chk_i.valid_errs
                 + dut_i.fetch_i.chk_i.hold_errs;
        if (mon_errs == 0 && chk_errs == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: filelist.f
+incdir+verilog
verilog/fetch_pkg.sv
verilog/bpred.sv
verilog/imem.sv
verilog/fetch.sv
verilog/fetch_top.sv
tests/fetch_chk.sv
tests/fetch_monitor.sv
tests/fetch_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the fetch stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f filelist.f --top-module fetch_tb -Mdir obj_dir -o fetch_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/fetch_sim +verilator+error+limit+100)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^Verification passed$"; then
    exit 0
fi
exit 1
